// File: include/clock_tb_checks.svh
// Clock testbench checks
`ifndef CLOCK_TB_CHECKS_SVH
`define CLOCK_TB_CHECKS_SVH

task automatic abort_run(input string reason);
	$display("%s", reason);
	$display("CHECKS FAILED");
	$fatal(1, "run stopped at the first error");
endtask

task automatic check_unit(input string name, input clock_pkg::unit_t got,
		input clock_pkg::unit_t exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
endtask

task automatic check_seg(input string name, input display_pkg::seg_t got,
		input display_pkg::seg_t exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
endtask

task automatic check_enb(input string name, input display_pkg::enb_t got,
		input display_pkg::enb_t exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
endtask

task automatic check_mode(input string name, input clock_pkg::mode_t got,
		input clock_pkg::mode_t exp);
	if (got !== exp)
		abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
endtask

// --------------------------------------------------
// display read over two blink periods
// --------------------------------------------------
task automatic read_display();
	display_pkg::seg_t seen_seg [display_pkg::NUM_DIGITS];
	int                lit [display_pkg::NUM_DIGITS];
	bit                seen [display_pkg::NUM_DIGITS];
	int                lows;
	int                k;
	bit                edited;
	clock_pkg::unit_t  val;
	clock_pkg::unit_t  got;
	for (int d = 0; d < display_pkg::NUM_DIGITS; d++) begin
		lit[d]      = 0;
		seen[d]     = 1'b0;
		seen_seg[d] = '0;
	end
	align_to_second(SETTLE_PHASE);
	repeat (READ_CYCLES) begin
		@(negedge clk);
		lows = 0;
		k    = 0;
		for (int d = 0; d < display_pkg::NUM_DIGITS; d++) begin
			if (!o_seg_enb[d]) begin
				lows++;
				k = d;
			end
		end
		if (lows > 1)
			abort_run($sformatf("Mismatch o_seg_enb: got %h, expected one low bit", o_seg_enb));
		if (lows == 0 && m_mode == clock_pkg::MODE_RUN)
			abort_run("all digits were dark while the clock was in run mode");
		if (lows == 1) begin
			lit[k]++;
			if (cyc % SEC_DIV >= GUARD) begin	// skip the carry ripple
				val = m_units[k / 2];
				check_seg($sformatf("o_seg digit %0d", k), o_seg,
					display_pkg::SEG_PATTERN[(k % 2 == 0) ? val % 10 : val / 10]);
				seen_seg[k] = o_seg;
				seen[k]     = 1'b1;
			end
		end
	end
	for (int d = 0; d < display_pkg::NUM_DIGITS; d++) begin
		edited = (m_mode == clock_pkg::MODE_SETUP) && (d / 2 == int'(m_pos));
		if (!seen[d])
			abort_run($sformatf("digit %0d was never shown during the read", d));
		if (edited && lit[d] >= MIN_LIT)
			abort_run($sformatf("digit %0d of the edited unit did not blink", d));
		if (!edited && lit[d] < MIN_LIT)
			abort_run($sformatf("digit %0d was blanked though it is not edited", d));
	end
	// back from segments to unit values
	for (int u = 0; u < clock_pkg::NUM_UNITS; u++) begin
		got = '0;
		for (int j = 0; j < 10; j++) begin
			if (seen_seg[2*u] == display_pkg::SEG_PATTERN[j])
				got = got + clock_pkg::unit_t'(j);
			if (seen_seg[2*u+1] == display_pkg::SEG_PATTERN[j])
				got = got + clock_pkg::unit_t'(10 * j);
		end
		check_unit($sformatf("unit %0d", u), got, m_units[u]);
	end
endtask

`endif

// File: dv/clock_tb.sv
// Six-digit clock testbench
`timescale 1ns/1ps
`default_nettype none

module clock_tb;

	localparam int SEC_DIV    = 200;
	localparam int SCAN_DIV   = 4;
	localparam int SAMPLE_DIV = 8;
	localparam int BLINK_DIV  = 64;

	localparam int READ_CYCLES  = 4 * BLINK_DIV;	// two blink periods
	localparam int MIN_LIT      = READ_CYCLES / display_pkg::NUM_DIGITS - SCAN_DIV;
	localparam int GUARD        = 4;	// cycles for the carry chain after a second
	localparam int SETTLE_PHASE = 8;
	localparam int PRESS_PHASE  = 10;	// presses start just after a second
	localparam int RELEASE_SMP  = 3;
	localparam int PRESS_CYCLES = (6 + RELEASE_SMP) * SAMPLE_DIV + 2;
	localparam int MAX_ROWS     = 16;

	typedef enum int {ACT_RUN, ACT_MODE, ACT_POS, ACT_INC} act_t;

	logic              clk;
	logic              rst_n;
	logic              i_btn_mode;
	logic              i_btn_pos;
	logic              i_btn_inc;
	display_pkg::seg_t o_seg;
	display_pkg::enb_t o_seg_enb;
	logic              o_setup;

	act_t row_act [MAX_ROWS];
	int   row_cnt [MAX_ROWS];
	bit   row_read [MAX_ROWS];
	int   num_rows = 0;

	// reference model
	int                   cyc = 0;	// cycles since reset release
	int                   sec_count = 0;
	clock_pkg::unit_t     m_units [clock_pkg::NUM_UNITS];
	clock_pkg::mode_t     m_mode;
	clock_pkg::unit_idx_t m_pos;

	clock_top #(
		.SEC_DIV    (SEC_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV),
		.BLINK_DIV  (BLINK_DIV)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_btn_mode (i_btn_mode),
		.i_btn_pos  (i_btn_pos),
		.i_btn_inc  (i_btn_inc),
		.o_seg      (o_seg),
		.o_seg_enb  (o_seg_enb),
		.o_setup    (o_setup)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic step_unit(input int u);
		m_units[u] = (m_units[u] == clock_pkg::MAX_COUNT[u]) ? '0 : m_units[u] + 1'b1;
	endtask

	task automatic advance_time();
		bit carry;
		carry = 1'b1;
		for (int u = 0; u < clock_pkg::NUM_UNITS; u++) begin
			if (carry) begin
				carry = (m_units[u] == clock_pkg::MAX_COUNT[u]);
				step_unit(u);
			end
		end
	endtask

	// one second every SEC_DIV cycles after reset
	always @(posedge clk) begin
		if (rst_n) begin
			cyc <= cyc + 1;
			if ((cyc + 1) % SEC_DIV == 0) begin
				sec_count <= sec_count + 1;
				if (m_mode == clock_pkg::MODE_RUN)
					advance_time();
			end
		end
	end

	task automatic align_to_second(input int phase);
		@(negedge clk);
		while (cyc % SEC_DIV != phase) @(negedge clk);
	endtask

	task automatic press_button(input int which);
		int hold;
		hold = 3 + int'($urandom % 4);	// sample periods
		@(posedge clk);
		case (which)
			0:       i_btn_mode <= 1'b1;
			1:       i_btn_pos  <= 1'b1;
			default: i_btn_inc  <= 1'b1;
		endcase
		repeat (hold * SAMPLE_DIV) @(posedge clk);
		i_btn_mode <= 1'b0;
		i_btn_pos  <= 1'b0;
		i_btn_inc  <= 1'b0;
		repeat (RELEASE_SMP * SAMPLE_DIV) @(posedge clk);
	endtask

	`include "clock_tb_checks.svh"

	// --------------------------------------------------
	// stimulus table
	// --------------------------------------------------
	task automatic add_row(input act_t act, input int cnt, input bit rd);
		row_act[num_rows]  = act;
		row_cnt[num_rows]  = cnt;
		row_read[num_rows] = rd;
		num_rows++;
	endtask

	task automatic load_table();
		add_row(ACT_RUN, 62, 1);	// carry into minutes
		add_row(ACT_MODE, 1, 1);	// setup entered at 00:01:05
		add_row(ACT_RUN, 3, 1);	// frozen
		add_row(ACT_INC, 53, 1);	// seconds to 58
		add_row(ACT_POS, 1, 1);
		add_row(ACT_INC, 58, 1);	// minutes to 59
		add_row(ACT_INC, 1, 1);	// 59 + 1 without carry
		add_row(ACT_INC, 59, 1);
		add_row(ACT_POS, 1, 1);
		add_row(ACT_INC, 23, 1);	// 23:59:58
		add_row(ACT_MODE, 1, 0);
		add_row(ACT_RUN, 2, 1);	// rolls over to 00:00:00
		add_row(ACT_MODE, 1, 1);
		add_row(ACT_INC, 1, 1);
		add_row(ACT_POS, 1, 1);	// hours back to seconds
		add_row(ACT_INC, 1, 1);
	endtask

	function automatic int run_budget();
		int total;
		total = 10 + SEC_DIV + READ_CYCLES;
		for (int r = 0; r < num_rows; r++) begin
			case (row_act[r])
				ACT_RUN: total += (row_cnt[r] + 1) * SEC_DIV;
				ACT_INC: total += row_cnt[r] * PRESS_CYCLES;
				default: total += SEC_DIV + PRESS_CYCLES;
			endcase
			if (row_read[r])
				total += SEC_DIV + READ_CYCLES;
		end
		return total;
	endfunction

	initial begin : watchdog
		int limit;
		@(posedge clk);
		limit = run_budget() * 6 / 5;
		repeat (limit) @(posedge clk);
		abort_run("timeout: the stimulus table did not finish within its cycle budget");
	end

	initial begin
		int seed;
		int target;
		seed       = $urandom(18);
		rst_n      = 1'b0;
		i_btn_mode = 1'b0;
		i_btn_pos  = 1'b0;
		i_btn_inc  = 1'b0;
		m_mode     = clock_pkg::MODE_RUN;
		m_pos      = clock_pkg::SEL_SEC;
		for (int u = 0; u < clock_pkg::NUM_UNITS; u++)
			m_units[u] = '0;
		load_table();
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_enb("o_seg_enb", o_seg_enb, 6'h3E);
		check_mode("o_setup", clock_pkg::mode_t'(o_setup), clock_pkg::MODE_RUN);
		read_display();

		for (int r = 0; r < num_rows; r++) begin
			case (row_act[r])
				ACT_RUN: begin
					target = sec_count + row_cnt[r];
					while (sec_count < target) @(negedge clk);
				end
				ACT_MODE: begin
					align_to_second(PRESS_PHASE);
					m_mode = (m_mode == clock_pkg::MODE_RUN) ?
						clock_pkg::MODE_SETUP : clock_pkg::MODE_RUN;
					press_button(0);
				end
				ACT_POS: begin
					if (m_mode == clock_pkg::MODE_RUN)
						align_to_second(PRESS_PHASE);
					case (m_pos)
						clock_pkg::SEL_SEC: m_pos = clock_pkg::SEL_MIN;
						clock_pkg::SEL_MIN: m_pos = clock_pkg::SEL_HOUR;
						default:            m_pos = clock_pkg::SEL_SEC;
					endcase
					press_button(1);
				end
				default: begin
					repeat (row_cnt[r]) begin
						if (m_mode == clock_pkg::MODE_SETUP)
							step_unit(m_pos);	// ignored in run mode
						press_button(2);
					end
				end
			endcase
			if (row_read[r]) begin
				read_display();
				check_mode("o_setup", clock_pkg::mode_t'(o_setup), m_mode);
			end
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
source/clock_pkg.sv
source/display_pkg.sv
source/tick_gen.sv
source/time_ctrl.sv
source/unit_counter.sv
source/digit_scan.sv
source/clock_top.sv
dv/clock_tb.sv

// File: source/clock_pkg.sv
// Clock timekeeping definitions
`default_nettype none

package clock_pkg;

	// --------------------------------------------------
	// time units
	// --------------------------------------------------
	localparam int NUM_UNITS = 3;
	localparam int UNIT_W    = 6;	// enough for 0..59

	typedef logic [UNIT_W-1:0] unit_t;

	// edited position, also the counter index
	typedef enum logic [1:0] {
		SEL_SEC  = 2'd0,
		SEL_MIN  = 2'd1,
		SEL_HOUR = 2'd2
	} unit_idx_t;

	// last value before wrap, indexed by unit_idx_t
	localparam unit_t MAX_COUNT [NUM_UNITS] = '{
		unit_t'(59),	// seconds
		unit_t'(59),	// minutes
		unit_t'(23)	// hours
	};

	typedef enum logic {
		MODE_RUN   = 1'b0,
		MODE_SETUP = 1'b1
	} mode_t;

	// --------------------------------------------------
	// divider defaults for a 50 MHz clk
	// --------------------------------------------------
	localparam int SEC_DIV_DEF    = 50_000_000;	// 1 Hz
	localparam int SCAN_DIV_DEF   = 5_000;		// one digit per 100 us
	localparam int SAMPLE_DIV_DEF = 500_000;	// 100 Hz button sampling
	localparam int BLINK_DIV_DEF  = 25_000_000;	// half blink period

endpackage

`default_nettype wire

// File: source/clock_top.sv
// Six-digit clock top level
`timescale 1ns/1ps
`default_nettype none

module clock_top #(
	parameter int SEC_DIV    = clock_pkg::SEC_DIV_DEF,
	parameter int SCAN_DIV   = clock_pkg::SCAN_DIV_DEF,
	parameter int SAMPLE_DIV = clock_pkg::SAMPLE_DIV_DEF,
	parameter int BLINK_DIV  = clock_pkg::BLINK_DIV_DEF
) (
	input  wire               clk,
	input  wire               rst_n,
	input  wire               i_btn_mode,
	input  wire               i_btn_pos,
	input  wire               i_btn_inc,
	output display_pkg::seg_t o_seg,
	output display_pkg::enb_t o_seg_enb,
	output logic              o_setup
);

	logic sec_tick;
	logic scan_tick;
	logic sample_tick;
	logic blink_tick;

	clock_pkg::mode_t     mode;
	clock_pkg::unit_idx_t pos;
	logic [clock_pkg::NUM_UNITS-1:0] step;
	logic [clock_pkg::NUM_UNITS-1:0] wrap;
	clock_pkg::unit_t     units [clock_pkg::NUM_UNITS];

	// --------------------------------------------------
	// strobe dividers
	// --------------------------------------------------
	tick_gen #(.DIV(SEC_DIV))    u_sec_tick    (.clk, .rst_n, .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV))   u_scan_tick   (.clk, .rst_n, .o_tick(scan_tick));
	tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (.clk, .rst_n, .o_tick(sample_tick));
	tick_gen #(.DIV(BLINK_DIV))  u_blink_tick  (.clk, .rst_n, .o_tick(blink_tick));

	time_ctrl u_time_ctrl (
		.clk,
		.rst_n,
		.i_sample_tick (sample_tick),
		.i_sec_tick    (sec_tick),
		.i_btn_mode,
		.i_btn_pos,
		.i_btn_inc,
		.i_wrap        (wrap),
		.o_mode        (mode),
		.o_pos         (pos),
		.o_step        (step)
	);

	// seconds, minutes, hours
	for (genvar i = 0; i < clock_pkg::NUM_UNITS; i++) begin : g_unit
		unit_counter #(.MAX_COUNT(clock_pkg::MAX_COUNT[i])) u_unit_counter (
			.clk,
			.rst_n,
			.i_step  (step[i]),
			.o_value (units[i]),
			.o_wrap  (wrap[i])
		);
	end

	digit_scan u_digit_scan (
		.clk,
		.rst_n,
		.i_scan_tick  (scan_tick),
		.i_blink_tick (blink_tick),
		.i_units      (units),
		.i_mode       (mode),
		.i_pos        (pos),
		.o_seg,
		.o_seg_enb
	);

	assign o_setup = (mode == clock_pkg::MODE_SETUP);

endmodule

`default_nettype wire

// File: source/digit_scan.sv
// Multiplexed display driver
`timescale 1ns/1ps
`default_nettype none

module digit_scan (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  i_scan_tick,
	input  wire                  i_blink_tick,
	input  wire clock_pkg::unit_t i_units [clock_pkg::NUM_UNITS],
	input  wire clock_pkg::mode_t i_mode,
	input  wire clock_pkg::unit_idx_t i_pos,
	output display_pkg::seg_t    o_seg,
	output display_pkg::enb_t    o_seg_enb
);

	localparam int PTR_W = $clog2(display_pkg::NUM_DIGITS);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(display_pkg::NUM_DIGITS - 1);

	display_pkg::bcd_t digit [display_pkg::NUM_DIGITS];
	display_pkg::bcd_t cur_digit;
	display_pkg::enb_t blank_mask;
	logic [PTR_W-1:0]  ptr;
	logic [PTR_W-1:0]  ptr_nxt;
	logic              blink_ph;	// 0 hides the edited unit

	// --------------------------------------------------
	// tens/ones split, ones on the even digit
	// --------------------------------------------------
	always_comb begin
		for (int u = 0; u < clock_pkg::NUM_UNITS; u++) begin
			digit[2*u]   = display_pkg::bcd_t'(i_units[u] % 10);
			digit[2*u+1] = display_pkg::bcd_t'(i_units[u] / 10);
		end
	end

	always_comb begin
		ptr_nxt = ptr;
		if (i_scan_tick) begin
			ptr_nxt = (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
		end
	end

	// two digits of the edited unit
	always_comb begin
		blank_mask = '0;
		if (i_mode == clock_pkg::MODE_SETUP && !blink_ph) begin
			blank_mask[2*i_pos +: 2] = 2'b11;
		end
	end

	// --------------------------------------------------
	// scan pointer, blink phase, enables
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr       <= '0;
			blink_ph  <= 1'b0;
			o_seg_enb <= ~display_pkg::enb_t'(1);	// seconds ones lit
		end else begin
			ptr <= ptr_nxt;
			if (i_blink_tick) begin
				blink_ph <= ~blink_ph;
			end
			o_seg_enb <= ~(display_pkg::enb_t'(1) << ptr_nxt) | blank_mask;
		end
	end

	// decode of the pointed digit
	always_comb begin
		cur_digit = digit[ptr];
		if (cur_digit <= 4'd9) begin
			o_seg = display_pkg::SEG_PATTERN[cur_digit];
		end else begin
			o_seg = display_pkg::SEG_BLANK;
		end
	end

	a_one_enable: assert property (@(posedge clk) disable iff (!rst_n)
		$countones(~o_seg_enb) <= 1);

endmodule

`default_nettype wire

// File: source/display_pkg.sv
// Seven-segment display definitions
`default_nettype none

package display_pkg;

	localparam int NUM_DIGITS = 6;

	// segments a..g, a in the high bit, active high
	typedef logic [6:0] seg_t;

	// one decimal digit
	typedef logic [3:0] bcd_t;

	// digit enables, active low
	typedef logic [NUM_DIGITS-1:0] enb_t;

	// --------------------------------------------------
	// segment patterns for 0..9
	// --------------------------------------------------
	localparam seg_t SEG_PATTERN [10] = '{
		7'h7E,	// 0
		7'h30,	// 1
		7'h6D,	// 2
		7'h79,	// 3
		7'h33,	// 4
		7'h5B,	// 5
		7'h5F,	// 6
		7'h70,	// 7
		7'h7F,	// 8
		7'h73	// 9
	};

	// blank pattern for anything above 9
	localparam seg_t SEG_BLANK = 7'h00;

endpackage

`default_nettype wire

// File: source/tick_gen.sv
// Periodic strobe generator
`timescale 1ns/1ps
`default_nettype none

module tick_gen #(
	parameter int DIV = 2
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_tick
);

	localparam int CNT_W = $clog2(DIV);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else begin
			if (cnt == CNT_LAST) begin
				cnt    <= '0;
				o_tick <= 1'b1;	// strobe on the wrap
			end else begin
				cnt    <= cnt + 1'b1;
				o_tick <= 1'b0;
			end
		end
	end

	// strobe lasts exactly one cycle
	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n) o_tick |=> !o_tick);

endmodule

`default_nettype wire

// File: source/time_ctrl.sv
// Button handling and step routing
`timescale 1ns/1ps
`default_nettype none

module time_ctrl (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  i_sample_tick,
	input  wire                  i_sec_tick,
	input  wire                  i_btn_mode,
	input  wire                  i_btn_pos,
	input  wire                  i_btn_inc,
	input  wire  [2:0]           i_wrap,
	output clock_pkg::mode_t     o_mode,
	output clock_pkg::unit_idx_t o_pos,
	output logic [2:0]           o_step
);

	localparam int BTN_MODE = 0;
	localparam int BTN_POS  = 1;
	localparam int BTN_INC  = 2;

	logic [2:0] btn_smp;	// latest sample
	logic [2:0] btn_prev;	// sample before that
	logic       smp_d;	// a sample was taken last edge
	logic [2:0] press;

	// --------------------------------------------------
	// sampling and edge detect
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_smp  <= '0;
			btn_prev <= '0;
			smp_d    <= 1'b0;
		end else begin
			smp_d <= i_sample_tick;
			if (i_sample_tick) begin
				btn_smp  <= {i_btn_inc, i_btn_pos, i_btn_mode};
				btn_prev <= btn_smp;
			end
		end
	end

	// rising level between two samples, valid for one cycle
	assign press = smp_d ? (btn_smp & ~btn_prev) : 3'b000;

	// --------------------------------------------------
	// mode and edit position
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= clock_pkg::MODE_RUN;
			o_pos  <= clock_pkg::SEL_SEC;
		end else begin
			if (press[BTN_MODE]) begin
				o_mode <= (o_mode == clock_pkg::MODE_RUN) ?
					clock_pkg::MODE_SETUP : clock_pkg::MODE_RUN;
			end
			if (press[BTN_POS]) begin
				case (o_pos)
					clock_pkg::SEL_SEC: o_pos <= clock_pkg::SEL_MIN;
					clock_pkg::SEL_MIN: o_pos <= clock_pkg::SEL_HOUR;
					default:            o_pos <= clock_pkg::SEL_SEC;
				endcase
			end
		end
	end

	// run: second tick plus carry chain; setup: inc press on the selected unit only
	always_comb begin
		o_step = 3'b000;
		if (o_mode == clock_pkg::MODE_RUN) begin
			o_step = {i_wrap[1:0], i_sec_tick};
		end else begin
			o_step[o_pos] = press[BTN_INC];
		end
	end

	a_step_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(o_step));

endmodule

`default_nettype wire

// File: source/unit_counter.sv
// Modulo counter for one time unit
`timescale 1ns/1ps
`default_nettype none

module unit_counter #(
	parameter clock_pkg::unit_t MAX_COUNT = clock_pkg::unit_t'(59)
) (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              i_step,
	output clock_pkg::unit_t o_value,
	output logic             o_wrap
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_value <= '0;
			o_wrap  <= 1'b0;
		end else begin
			o_wrap <= 1'b0;
			if (i_step) begin
				if (o_value == MAX_COUNT) begin
					o_value <= '0;
					o_wrap  <= 1'b1;	// carry for the next unit
				end else begin
					o_value <= o_value + 1'b1;
				end
			end
		end
	end

	a_value_range: assert property (@(posedge clk) disable iff (!rst_n) o_value <= MAX_COUNT);

endmodule

`default_nettype wire
